//--- src/null_src_sink_defines.svh
// Data path and register port widths, register map,
// CHDR header field positions and source config reset values
`ifndef NULL_SRC_SINK_DEFINES_SVH
`define NULL_SRC_SINK_DEFINES_SVH

// Stream and item widths
`define CHDR_W                  64
`define ITEM_W                  32
`define NIPC                    (`CHDR_W / `ITEM_W)
`define CNT_W                   64

// Register port
`define CTRL_ADDR_W             20
`define CTRL_DATA_W             32

// Register map
`define REG_CTRL_STATUS         20'h00
`define REG_SRC_LINES_PER_PKT   20'h04
`define REG_SRC_BYTES_PER_PKT   20'h08
`define REG_SRC_THROTTLE_CYC    20'h0C
`define REG_SNK_LINE_CNT_LO     20'h10
`define REG_SNK_LINE_CNT_HI     20'h14
`define REG_SNK_PKT_CNT_LO      20'h18
`define REG_SNK_PKT_CNT_HI      20'h1C
`define REG_SRC_LINE_CNT_LO     20'h20
`define REG_SRC_LINE_CNT_HI     20'h24
`define REG_SRC_PKT_CNT_LO      20'h28
`define REG_SRC_PKT_CNT_HI      20'h2C
`define REG_LOOP_LINE_CNT_LO    20'h30
`define REG_LOOP_LINE_CNT_HI    20'h34
`define REG_LOOP_PKT_CNT_LO     20'h38
`define REG_LOOP_PKT_CNT_HI     20'h3C
`define REG_SRC_NUM_PKT_LO      20'h40
`define REG_SRC_NUM_PKT_HI      20'h44

// CHDR header fields
`define CHDR_EOB_BIT            57
`define CHDR_TYPE_MSB           55
`define CHDR_TYPE_LSB           53
`define CHDR_SEQ_MSB            47
`define CHDR_SEQ_LSB            32
`define CHDR_LEN_MSB            31
`define CHDR_LEN_LSB            16
`define CHDR_PKT_TYPE_DATA      3'd6

// Source config after reset
`define SRC_LPP_RST             12'd0
`define SRC_BPP_RST             16'd0
`define SRC_THROTTLE_RST        20'd0
`define SRC_NUM_PKT_RST         48'd0

`endif

//--- src/null_src_sink_pkg.sv
// Shared types: CHDR stream word, register request and response,
// source configuration, traffic counters and source FSM states
`include "null_src_sink_defines.svh"

package null_src_sink_pkg;

  // One word of a CHDR stream, header or payload
  typedef struct packed {
    logic [`CHDR_W-1:0] tdata;
    logic               tlast;
  } chdr_beat_t;

  // Register request, wr or rd held for one cycle
  typedef struct packed {
    logic                    wr;
    logic                    rd;
    logic [`CTRL_ADDR_W-1:0] addr;
    logic [`CTRL_DATA_W-1:0] data;
  } ctrl_req_t;

  typedef struct packed {
    logic                    ack;
    logic [`CTRL_DATA_W-1:0] data;
  } ctrl_resp_t;

  // Source setup
  typedef struct packed {
    logic        en;
    logic        finite;
    logic [11:0] lpp;       // payload lines minus one
    logic [15:0] bpp;       // packet bytes, header included
    logic [19:0] throttle;
    logic [47:0] num_pkt;
  } src_cfg_t;

  typedef struct packed {
    logic [`CNT_W-1:0] snk_line;
    logic [`CNT_W-1:0] snk_pkt;
    logic [`CNT_W-1:0] src_line;
    logic [`CNT_W-1:0] src_pkt;
    logic [`CNT_W-1:0] loop_line;
    logic [`CNT_W-1:0] loop_pkt;
  } traffic_cnt_t;

  typedef enum logic [1:0] {
    SRC_IDLE = 2'd0,
    SRC_HDR  = 2'd1,
    SRC_PYLD = 2'd2,
    SRC_WAIT = 2'd3
  } src_state_e;

endpackage

//--- src/ctrl_regs.sv
// Register block: write decode into the source config, counter clear pulse,
// read mux with a latch that keeps 64-bit counter reads consistent
`timescale 1ns/10ps
`include "null_src_sink_defines.svh"

module ctrl_regs (
  input  logic                            rfnoc_chdr_clk,
  input  logic                            rfnoc_chdr_rst,
  input  null_src_sink_pkg::ctrl_req_t    ctrl_req,
  output null_src_sink_pkg::ctrl_resp_t   ctrl_resp,
  input  null_src_sink_pkg::traffic_cnt_t cnt,
  input  null_src_sink_pkg::src_state_e   src_state,
  input  logic                            src_last_done,
  output null_src_sink_pkg::src_cfg_t     src_cfg,
  output logic                            cnt_clear
);
  import null_src_sink_pkg::*;

  logic                    resp_ack;
  logic [`CTRL_DATA_W-1:0] resp_data;
  // Upper counter half, captured by the LO read
  logic [`CTRL_DATA_W-1:0] hi_latch;
  logic [`CNT_W-1:0]       cnt_sel;
  logic                    cnt_hit;

  // ----------------------------------------------------------------------
  // Writes
  // ----------------------------------------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      src_cfg <= src_cfg_t'{
        en:       1'b0,
        finite:   1'b0,
        lpp:      `SRC_LPP_RST,
        bpp:      `SRC_BPP_RST,
        throttle: `SRC_THROTTLE_RST,
        num_pkt:  `SRC_NUM_PKT_RST
      };
      cnt_clear <= 1'b0;
    end else begin
      cnt_clear <= 1'b0;
      // Finite run is over, the source drops back to idle
      if (src_last_done) begin
        src_cfg.en <= 1'b0;
      end
      if (ctrl_req.wr) begin
        case (ctrl_req.addr)
          `REG_CTRL_STATUS: begin
            src_cfg.finite <= ctrl_req.data[2];
            src_cfg.en     <= ctrl_req.data[1];
            cnt_clear      <= ctrl_req.data[0];
          end
          `REG_SRC_LINES_PER_PKT: src_cfg.lpp           <= ctrl_req.data[11:0];
          `REG_SRC_BYTES_PER_PKT: src_cfg.bpp           <= ctrl_req.data[15:0];
          `REG_SRC_THROTTLE_CYC:  src_cfg.throttle      <= ctrl_req.data[19:0];
          `REG_SRC_NUM_PKT_LO:    src_cfg.num_pkt[31:0]  <= ctrl_req.data;
          `REG_SRC_NUM_PKT_HI:    src_cfg.num_pkt[47:32] <= ctrl_req.data[15:0];
          default: begin
          end
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // Reads
  // ----------------------------------------------------------------------
  // Counter behind a LO or HI address
  always_comb begin
    cnt_hit = 1'b1;
    cnt_sel = '0;
    case (ctrl_req.addr)
      `REG_SNK_LINE_CNT_LO,  `REG_SNK_LINE_CNT_HI:  cnt_sel = cnt.snk_line;
      `REG_SNK_PKT_CNT_LO,   `REG_SNK_PKT_CNT_HI:   cnt_sel = cnt.snk_pkt;
      `REG_SRC_LINE_CNT_LO,  `REG_SRC_LINE_CNT_HI:  cnt_sel = cnt.src_line;
      `REG_SRC_PKT_CNT_LO,   `REG_SRC_PKT_CNT_HI:   cnt_sel = cnt.src_pkt;
      `REG_LOOP_LINE_CNT_LO, `REG_LOOP_LINE_CNT_HI: cnt_sel = cnt.loop_line;
      `REG_LOOP_PKT_CNT_LO,  `REG_LOOP_PKT_CNT_HI:  cnt_sel = cnt.loop_pkt;
      default:                                      cnt_hit = 1'b0;
    endcase
  end

  // Every request is answered on the next cycle
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      resp_ack <= 1'b0;
    end else begin
      resp_ack <= ctrl_req.wr | ctrl_req.rd;
    end
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (ctrl_req.rd) begin
      if (cnt_hit) begin
        // Address bit 2 tells HI from LO
        if (!ctrl_req.addr[2]) begin
          resp_data <= cnt_sel[31:0];
          hi_latch  <= cnt_sel[63:32];
        end else begin
          resp_data <= hi_latch;
        end
      end else begin
        case (ctrl_req.addr)
          `REG_CTRL_STATUS:
            resp_data <= {8'(`NIPC), 8'(`ITEM_W), src_state, 11'd0,
                          src_cfg.finite, src_cfg.en, 1'b0};
          `REG_SRC_LINES_PER_PKT: resp_data <= {20'd0, src_cfg.lpp};
          `REG_SRC_BYTES_PER_PKT: resp_data <= {16'd0, src_cfg.bpp};
          `REG_SRC_THROTTLE_CYC:  resp_data <= {12'd0, src_cfg.throttle};
          `REG_SRC_NUM_PKT_LO:    resp_data <= src_cfg.num_pkt[31:0];
          `REG_SRC_NUM_PKT_HI:    resp_data <= {16'd0, src_cfg.num_pkt[47:32]};
          default:                resp_data <= '0;
        endcase
      end
    end
  end

  assign ctrl_resp = ctrl_resp_t'{ack: resp_ack, data: resp_data};

endmodule

//--- src/chdr_pkt_source.sv
// CHDR packet generator: FSM with header build, payload pattern,
// throttle gap between packets and finite packet count
`timescale 1ns/10ps
`include "null_src_sink_defines.svh"

module chdr_pkt_source (
  input  logic                          rfnoc_chdr_clk,
  input  logic                          rfnoc_chdr_rst,
  input  null_src_sink_pkg::src_cfg_t   src_cfg,
  output null_src_sink_pkg::chdr_beat_t src_out,
  output logic                          src_out_valid,
  input  logic                          src_out_ready,
  output null_src_sink_pkg::src_state_e src_state,
  output logic                          src_last_done
);
  import null_src_sink_pkg::*;

  src_state_e         state;
  src_state_e         state_next;
  logic [47:0]        pkt_idx;       // index of the packet whose header is next
  logic [11:0]        lines_left;
  logic [11:0]        line_idx;
  logic [19:0]        throttle_cnt;
  logic [`CHDR_W-1:0] hdr_q;
  logic [`CHDR_W-1:0] hdr_next;
  logic [15:0]        line_k;
  logic [`ITEM_W-1:0] item;
  logic               src_fire;
  logic               pkt_end;
  logic               load_hdr;

  assign src_fire = src_out_valid & src_out_ready;
  assign pkt_end  = (lines_left == 12'd0);
  assign load_hdr = (state_next == SRC_HDR) && (state != SRC_HDR);

  // Header of the next packet
  always_comb begin
    hdr_next = '0;
    hdr_next[`CHDR_EOB_BIT] = src_cfg.finite && (pkt_idx + 48'd1 == src_cfg.num_pkt);
    hdr_next[`CHDR_TYPE_MSB:`CHDR_TYPE_LSB] = `CHDR_PKT_TYPE_DATA;
    hdr_next[`CHDR_SEQ_MSB:`CHDR_SEQ_LSB]   = pkt_idx[15:0];
    hdr_next[`CHDR_LEN_MSB:`CHDR_LEN_LSB]   = src_cfg.bpp;
  end

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      SRC_IDLE: begin
        if (src_cfg.en) state_next = SRC_HDR;
      end
      SRC_HDR: begin
        if (src_fire) state_next = SRC_PYLD;
      end
      SRC_PYLD: begin
        if (src_fire && pkt_end) begin
          // EOB packet or enable dropped ends the run
          if (hdr_q[`CHDR_EOB_BIT] || !src_cfg.en) begin
            state_next = SRC_IDLE;
          end else if (src_cfg.throttle == 20'd0) begin
            state_next = SRC_HDR;
          end else begin
            state_next = SRC_WAIT;
          end
        end
      end
      default: begin
        if (!src_cfg.en) begin
          state_next = SRC_IDLE;
        end else if (throttle_cnt == 20'd0) begin
          state_next = SRC_HDR;
        end
      end
    endcase
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      state   <= SRC_IDLE;
      pkt_idx <= '0;
    end else begin
      state <= state_next;
      if (state_next == SRC_IDLE) begin
        pkt_idx <= '0;
      end else if (state == SRC_HDR && src_fire) begin
        pkt_idx <= pkt_idx + 48'd1;
      end
    end
  end

  // Header word, line counters and throttle countdown
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (load_hdr) begin
      hdr_q <= hdr_next;
    end
    if (state == SRC_HDR) begin
      lines_left <= src_cfg.lpp;
      line_idx   <= '0;
    end else if (state == SRC_PYLD && src_fire) begin
      lines_left <= lines_left - 12'd1;
      line_idx   <= line_idx + 12'd1;
    end
    if (state == SRC_PYLD) begin
      throttle_cnt <= src_cfg.throttle;
    end else if (state == SRC_WAIT) begin
      throttle_cnt <= throttle_cnt - 20'd1;
    end
  end

  // Item pattern is ~k above k
  assign line_k = 16'(line_idx);
  assign item   = {~line_k, line_k};

  assign src_out_valid = (state == SRC_HDR) || (state == SRC_PYLD);
  assign src_out = chdr_beat_t'{
    tdata: (state == SRC_PYLD) ? {`NIPC{item}} : hdr_q,
    tlast: (state == SRC_PYLD) && pkt_end
  };
  assign src_state     = state;
  assign src_last_done = src_fire && src_out.tlast && hdr_q[`CHDR_EOB_BIT];

endmodule

//--- src/traffic_counters.sv
// Line and packet counters for the sink, source and loopback streams
`timescale 1ns/10ps
`include "null_src_sink_defines.svh"

module traffic_counters (
  input  logic                            rfnoc_chdr_clk,
  input  logic                            rfnoc_chdr_rst,
  input  logic                            cnt_clear,
  input  logic                            snk_fire,
  input  logic                            src_fire,
  input  logic                            loop_fire,
  input  logic                            snk_last,
  input  logic                            src_last,
  input  logic                            loop_last,
  output null_src_sink_pkg::traffic_cnt_t cnt
);
  import null_src_sink_pkg::*;

  // Index 0 is the sink, 1 the source, 2 the loopback
  logic [2:0]        fire;
  logic [2:0]        last;
  logic [`CNT_W-1:0] line_cnt [3];
  logic [`CNT_W-1:0] pkt_cnt  [3];

  assign fire = {loop_fire, src_fire, snk_fire};
  assign last = {loop_last, src_last, snk_last};

  // Every word is a line, a word with tlast closes a packet
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst || cnt_clear) begin
      for (int i = 0; i < 3; i++) begin
        line_cnt[i] <= '0;
        pkt_cnt[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (fire[i]) begin
          line_cnt[i] <= line_cnt[i] + 1'b1;
          if (last[i]) begin
            pkt_cnt[i] <= pkt_cnt[i] + 1'b1;
          end
        end
      end
    end
  end

  assign cnt = traffic_cnt_t'{
    snk_line:  line_cnt[0],
    snk_pkt:   pkt_cnt[0],
    src_line:  line_cnt[1],
    src_pkt:   pkt_cnt[1],
    loop_line: line_cnt[2],
    loop_pkt:  pkt_cnt[2]
  };

endmodule

//--- src/null_src_sink_top.sv
// Null source and sink top level: register block, packet source and
// traffic counters, with an always-ready sink and a pass-through loopback
`timescale 1ns/10ps

module null_src_sink_top (
  input  logic                          rfnoc_chdr_clk,
  input  logic                          rfnoc_chdr_rst,
  // Register port
  input  null_src_sink_pkg::ctrl_req_t  ctrl_req,
  output null_src_sink_pkg::ctrl_resp_t ctrl_resp,
  // Sink
  input  null_src_sink_pkg::chdr_beat_t snk_in,
  input  logic                          snk_in_valid,
  output logic                          snk_in_ready,
  // Loopback
  input  null_src_sink_pkg::chdr_beat_t loop_in,
  input  logic                          loop_in_valid,
  output logic                          loop_in_ready,
  output null_src_sink_pkg::chdr_beat_t loop_out,
  output logic                          loop_out_valid,
  input  logic                          loop_out_ready,
  // Source
  output null_src_sink_pkg::chdr_beat_t src_out,
  output logic                          src_out_valid,
  input  logic                          src_out_ready
);
  import null_src_sink_pkg::*;

  src_cfg_t     src_cfg;
  src_state_e   src_state;
  traffic_cnt_t cnt;
  logic         cnt_clear;
  logic         src_last_done;

  // Sink takes every word and drops the data, only tlast is counted
  assign snk_in_ready = 1'b1;

  assign loop_out       = loop_in;
  assign loop_out_valid = loop_in_valid;
  assign loop_in_ready  = loop_out_ready;

  ctrl_regs u_ctrl_regs (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .ctrl_req       (ctrl_req),
    .ctrl_resp      (ctrl_resp),
    .cnt            (cnt),
    .src_state      (src_state),
    .src_last_done  (src_last_done),
    .src_cfg        (src_cfg),
    .cnt_clear      (cnt_clear)
  );

  chdr_pkt_source u_chdr_pkt_source (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .src_cfg        (src_cfg),
    .src_out        (src_out),
    .src_out_valid  (src_out_valid),
    .src_out_ready  (src_out_ready),
    .src_state      (src_state),
    .src_last_done  (src_last_done)
  );

  traffic_counters u_traffic_counters (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .cnt_clear      (cnt_clear),
    .snk_fire       (snk_in_valid & snk_in_ready),
    .src_fire       (src_out_valid & src_out_ready),
    .loop_fire      (loop_out_valid & loop_out_ready),
    .snk_last       (snk_in.tlast),
    .src_last       (src_out.tlast),
    .loop_last      (loop_out.tlast),
    .cnt            (cnt)
  );

endmodule

//--- testbench/tb_null_src_sink.sv
// Testbench for the null source and sink: register access, finite source runs
// with and without back-pressure, sink counters, loopback and counter clear
`timescale 1ns/10ps
`include "null_src_sink_defines.svh"

module tb_null_src_sink;
  import null_src_sink_pkg::*;

  localparam int TIMEOUT_CYC = 1000;

  logic       rfnoc_chdr_clk;
  logic       rfnoc_chdr_rst;
  ctrl_req_t  ctrl_req;
  ctrl_resp_t ctrl_resp;
  chdr_beat_t snk_in;
  logic       snk_in_valid;
  logic       snk_in_ready;
  chdr_beat_t loop_in;
  logic       loop_in_valid;
  logic       loop_in_ready;
  chdr_beat_t loop_out;
  logic       loop_out_valid;
  logic       loop_out_ready;
  chdr_beat_t src_out;
  logic       src_out_valid;
  logic       src_out_ready;

  int         err_cnt;
  int         chk_cnt;
  bit         aborted;

  null_src_sink_top u_dut (.*);

  initial rfnoc_chdr_clk = 1'b0;
  always #10 rfnoc_chdr_clk = ~rfnoc_chdr_clk;

  // ----------------------------------------------------------------------
  // Compare and error helpers
  // ----------------------------------------------------------------------
  task automatic check_word(input string name, input logic [`CTRL_DATA_W-1:0] exp,
                            input logic [`CTRL_DATA_W-1:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_beat(input string name, input chdr_beat_t exp, input chdr_beat_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %s: expected %h/%b, actual %h/%b",
               name, exp.tdata, exp.tlast, act.tdata, act.tlast);
    end
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("Error: %s", what);
  endtask

  task automatic report_timeout(input string what);
    aborted = 1'b1;
    report_error($sformatf("%s got no response within %0d cycles", what, TIMEOUT_CYC));
  endtask

  // ----------------------------------------------------------------------
  // Register port
  // ----------------------------------------------------------------------
  // Request for one cycle, ack expected on exactly the next one
  task automatic reg_access(input logic wr, input logic [`CTRL_ADDR_W-1:0] addr,
                            input logic [`CTRL_DATA_W-1:0] wdata,
                            output logic [`CTRL_DATA_W-1:0] rdata);
    @(negedge rfnoc_chdr_clk);
    chk_cnt++;
    if (ctrl_resp.ack !== 1'b0) begin
      report_error($sformatf("ack already high before the request to %h", addr));
    end
    ctrl_req      = '0;
    ctrl_req.wr   = wr;
    ctrl_req.rd   = !wr;
    ctrl_req.addr = addr;
    ctrl_req.data = wdata;
    @(negedge rfnoc_chdr_clk);
    ctrl_req = '0;
    chk_cnt++;
    if (ctrl_resp.ack !== 1'b1) begin
      report_error($sformatf("no ack one cycle after the request to %h", addr));
    end
    rdata = ctrl_resp.data;
  endtask

  task automatic reg_write(input logic [`CTRL_ADDR_W-1:0] addr,
                           input logic [`CTRL_DATA_W-1:0] data);
    logic [`CTRL_DATA_W-1:0] unused;
    reg_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_read(input logic [`CTRL_ADDR_W-1:0] addr,
                          output logic [`CTRL_DATA_W-1:0] data);
    reg_access(1'b0, addr, '0, data);
  endtask

  // LO read first, it latches the HI half
  task automatic check_cnt(input string name, input logic [`CTRL_ADDR_W-1:0] lo_addr,
                           input logic [`CNT_W-1:0] exp);
    logic [`CTRL_DATA_W-1:0] lo;
    logic [`CTRL_DATA_W-1:0] hi;
    reg_read(lo_addr, lo);
    reg_read(lo_addr + 20'h4, hi);
    check_word({name, " lo"}, exp[31:0], lo);
    check_word({name, " hi"}, exp[63:32], hi);
  endtask

  // Expected source word: header on line 0, then payload line k = line - 1
  function automatic chdr_beat_t exp_src_beat(input int pkt, input int line, input int lpp,
                                              input int bpp, input int npkt);
    chdr_beat_t  b;
    logic [15:0] k;
    b = '0;
    if (line == 0) begin
      b.tdata[`CHDR_EOB_BIT]                 = (pkt == npkt - 1);
      b.tdata[`CHDR_TYPE_MSB:`CHDR_TYPE_LSB] = `CHDR_PKT_TYPE_DATA;
      b.tdata[`CHDR_SEQ_MSB:`CHDR_SEQ_LSB]   = 16'(pkt);
      b.tdata[`CHDR_LEN_MSB:`CHDR_LEN_LSB]   = 16'(bpp);
    end else begin
      k       = 16'(line - 1);
      b.tdata = {2{~k, k}};
      b.tlast = (line == lpp + 1);
    end
    return b;
  endfunction

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic test_registers();
    logic [`CTRL_DATA_W-1:0] rd;
    reg_write(`REG_SRC_LINES_PER_PKT, 32'hFFFF_F123);
    reg_read(`REG_SRC_LINES_PER_PKT, rd);
    check_word("lines per packet", 32'h0000_0123, rd);
    reg_write(`REG_SRC_BYTES_PER_PKT, 32'h1234_BEEF);
    reg_read(`REG_SRC_BYTES_PER_PKT, rd);
    check_word("bytes per packet", 32'h0000_BEEF, rd);
    reg_write(`REG_SRC_THROTTLE_CYC, 32'hFFFA_BCDE);
    reg_read(`REG_SRC_THROTTLE_CYC, rd);
    check_word("throttle", 32'h000A_BCDE, rd);
    reg_write(`REG_SRC_NUM_PKT_LO, 32'hDEAD_BEEF);
    reg_read(`REG_SRC_NUM_PKT_LO, rd);
    check_word("num_pkt lo", 32'hDEAD_BEEF, rd);
    reg_write(`REG_SRC_NUM_PKT_HI, 32'hFFFF_1234);
    reg_read(`REG_SRC_NUM_PKT_HI, rd);
    check_word("num_pkt hi", 32'h0000_1234, rd);
    reg_write(20'h80, 32'hFFFF_FFFF);
    reg_read(20'h80, rd);
    check_word("undefined address", 32'h0, rd);
    // NIPC 2, ITEM_W 32, idle, finite and en low
    reg_read(`REG_CTRL_STATUS, rd);
    check_word("status after reset", {8'd2, 8'd32, 16'h0000}, rd);
  endtask

  // Three packets of 5 words, bpp 40, finite mode
  task automatic run_source(input string name, input logic [19:0] throttle, input bit bp);
    chdr_beat_t              got[$];
    logic [`CTRL_DATA_W-1:0] rd;
    logic [`CTRL_DATA_W-1:0] exp_gap;
    int                      idle;
    int                      gap;
    int                      extra;
    // Cycles without valid between two packets
    exp_gap = (throttle == 20'd0) ? 32'd0 : 32'(throttle) + 32'd1;
    reg_write(`REG_SRC_LINES_PER_PKT, 32'd3);
    reg_write(`REG_SRC_BYTES_PER_PKT, 32'd40);
    reg_write(`REG_SRC_THROTTLE_CYC, {12'd0, throttle});
    reg_write(`REG_SRC_NUM_PKT_LO, 32'd3);
    reg_write(`REG_SRC_NUM_PKT_HI, 32'd0);
    reg_write(`REG_CTRL_STATUS, 32'h6);
    // FSM sits in SRC_HDR while ready is still low
    reg_read(`REG_CTRL_STATUS, rd);
    check_word({name, " status while held"}, {8'd2, 8'd32, 16'h4006}, rd);
    idle = 0;
    gap  = 0;
    while (got.size() < 15 && !aborted) begin
      @(negedge rfnoc_chdr_clk);
      src_out_ready = bp ? ($urandom % 4 != 0) : 1'b1;
      if (!src_out_valid) gap++;
      if (src_out_valid && src_out_ready) begin
        if (got.size() % 5 == 0 && got.size() != 0) begin
          check_word($sformatf("%s gap before pkt %0d", name, got.size() / 5),
                     exp_gap, gap);
        end
        got.push_back(src_out);
        gap  = 0;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT_CYC) report_timeout({name, " source output"});
      end
    end
    // Nothing more may come after the EOB packet
    extra = 0;
    repeat (20) begin
      @(negedge rfnoc_chdr_clk);
      src_out_ready = 1'b1;
      if (src_out_valid) extra++;
    end
    src_out_ready = 1'b0;
    chk_cnt++;
    if (extra != 0) report_error($sformatf("%s: %0d words after the last packet", name, extra));
    for (int i = 0; i < got.size(); i++) begin
      check_beat($sformatf("%s pkt %0d word %0d", name, i / 5, i % 5),
                 exp_src_beat(i / 5, i % 5, 3, 40, 3), got[i]);
    end
    // finite still set, en cleared by the run, state idle
    reg_read(`REG_CTRL_STATUS, rd);
    check_word({name, " status"}, {8'd2, 8'd32, 16'h0004}, rd);
  endtask

  task automatic test_sink();
    int total;
    int len;
    int idle;
    total = 0;
    for (int p = 0; p < 4; p++) begin
      len = 1 + int'($urandom % 8);
      for (int w = 0; w < len; w++) begin
        @(negedge rfnoc_chdr_clk);
        snk_in.tdata = {$urandom, $urandom};
        snk_in.tlast = (w == len - 1);
        snk_in_valid = 1'b1;
        idle = 0;
        while (!snk_in_ready && !aborted) begin
          @(negedge rfnoc_chdr_clk);
          idle++;
          if (idle > TIMEOUT_CYC) report_timeout("sink input");
        end
        total++;
      end
    end
    @(negedge rfnoc_chdr_clk);
    snk_in_valid = 1'b0;
    check_cnt("sink lines", `REG_SNK_LINE_CNT_LO, 64'(total));
    check_cnt("sink packets", `REG_SNK_PKT_CNT_LO, 64'd4);
  endtask

  task automatic test_loopback_clear();
    chdr_beat_t sent[$];
    chdr_beat_t b;
    int         len;
    int         idx;
    int         idle;
    for (int p = 0; p < 3; p++) begin
      len = 1 + int'($urandom % 6);
      for (int w = 0; w < len; w++) begin
        b.tdata = {$urandom, $urandom};
        b.tlast = (w == len - 1);
        sent.push_back(b);
      end
    end
    idx  = 0;
    idle = 0;
    while (idx < sent.size() && !aborted) begin
      @(negedge rfnoc_chdr_clk);
      loop_in        = sent[idx];
      loop_in_valid  = 1'b1;
      loop_out_ready = 1'($urandom % 2);
      #1;
      chk_cnt++;
      if (loop_out_valid !== 1'b1 || loop_in_ready !== loop_out_ready) begin
        report_error("loopback valid or ready does not pass straight through");
      end
      if (loop_out_valid && loop_out_ready) begin
        check_beat($sformatf("loopback word %0d", idx), sent[idx], loop_out);
        idx++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT_CYC) report_timeout("loopback output");
      end
    end
    @(negedge rfnoc_chdr_clk);
    loop_in_valid  = 1'b0;
    loop_out_ready = 1'b0;
    #1;
    chk_cnt++;
    if (loop_out_valid !== 1'b0) begin
      report_error("loop_out_valid stays high with loop_in_valid low");
    end
    check_cnt("loopback lines", `REG_LOOP_LINE_CNT_LO, 64'(sent.size()));
    check_cnt("loopback packets", `REG_LOOP_PKT_CNT_LO, 64'd3);
    // Clear pulse, then every counter reads zero
    reg_write(`REG_CTRL_STATUS, 32'h1);
    check_cnt("cleared sink lines", `REG_SNK_LINE_CNT_LO, 64'd0);
    check_cnt("cleared sink packets", `REG_SNK_PKT_CNT_LO, 64'd0);
    check_cnt("cleared source lines", `REG_SRC_LINE_CNT_LO, 64'd0);
    check_cnt("cleared source packets", `REG_SRC_PKT_CNT_LO, 64'd0);
    check_cnt("cleared loopback lines", `REG_LOOP_LINE_CNT_LO, 64'd0);
    check_cnt("cleared loopback packets", `REG_LOOP_PKT_CNT_LO, 64'd0);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(32'h3092));
    err_cnt        = 0;
    chk_cnt        = 0;
    aborted        = 1'b0;
    rfnoc_chdr_rst = 1'b1;
    ctrl_req       = '0;
    snk_in         = '0;
    snk_in_valid   = 1'b0;
    loop_in        = '0;
    loop_in_valid  = 1'b0;
    loop_out_ready = 1'b0;
    src_out_ready  = 1'b0;
    repeat (3) @(posedge rfnoc_chdr_clk);
    @(negedge rfnoc_chdr_clk);
    rfnoc_chdr_rst = 1'b0;

    test_registers();
    if (!aborted) run_source("finite run", 20'd0, 1'b0);
    if (!aborted) run_source("back-pressure run", 20'd4, 1'b1);
    if (!aborted) begin
      // Both runs together
      check_cnt("source lines", `REG_SRC_LINE_CNT_LO, 64'd30);
      check_cnt("source packets", `REG_SRC_PKT_CNT_LO, 64'd6);
    end
    if (!aborted) test_sink();
    if (!aborted) test_loopback_clear();

    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+src
src/null_src_sink_pkg.sv
src/ctrl_regs.sv
src/chdr_pkt_source.sv
src/traffic_counters.sv
src/null_src_sink_top.sv
testbench/tb_null_src_sink.sv

//--- Makefile
TOP := tb_null_src_sink

.PHONY: simulate clean

simulate:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
